// ==== common/pow_pkg.sv ====
package pow_pkg;

    // Datapath widths.
    localparam int data_w   = 8;
    localparam int n_stages = 4;

    // Step divider and completion counter widths.
    localparam int div_w = 8;
    localparam int cnt_w = 8;

    // APB widths.
    localparam int apb_addr_w = 4;
    localparam int apb_data_w = 32;

    // Register offsets.
    localparam logic [apb_addr_w - 1:0] addr_ctrl    = 4'h0;
    localparam logic [apb_addr_w - 1:0] addr_operand = 4'h4;
    localparam logic [apb_addr_w - 1:0] addr_status  = 4'h8;
    localparam logic [apb_addr_w - 1:0] addr_result  = 4'hC;

    // Master to slave.
    typedef struct packed
    {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [apb_addr_w - 1:0]   paddr;
        logic [apb_data_w - 1:0]   pwdata;
    } apb_req_t;

    // Slave to master.
    typedef struct packed
    {
        logic [apb_data_w - 1:0]   prdata;
        logic                      pready;
        logic                      pslverr;
    } apb_rsp_t;

    // Pipeline word, power k sits in lane k-2 of pows.
    typedef struct packed
    {
        logic                                  vld;
        logic [data_w - 1:0]                   n;
        logic [data_w - 1:0]                   acc;
        logic [n_stages - 1:0][data_w - 1:0]   pows;
    } pow_item_t;

endpackage

// ==== design/step_strobe.sv ====
`timescale 1ns/10ps

module step_strobe
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [pow_pkg::div_w - 1:0] div_ratio,
    output logic                       step
);

    logic [pow_pkg::div_w - 1:0] cnt;

    // Down-counter, reloads on zero.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt  <= '0;
            step <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= div_ratio;
            step <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            step <= 1'b0;
        end
    end

endmodule

// ==== pow_pipe/pow_stage.sv ====
`timescale 1ns/10ps

module pow_stage
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               step,
    input  pow_pkg::pow_item_t d,
    output pow_pkg::pow_item_t q
);

    logic                                                  vld_q;
    logic [pow_pkg::data_w - 1:0]                          n_q;
    logic [pow_pkg::data_w - 1:0]                          acc_q;
    logic [pow_pkg::n_stages - 1:0][pow_pkg::data_w - 1:0] pows_q;
    logic [pow_pkg::data_w - 1:0]                          prod;

    // Truncated to data_w bits.
    assign prod = d.acc * d.n;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            vld_q <= 1'b0;
        else if (step)
            vld_q <= d.vld;
    end

    // The product enters the top lane; earlier lanes move down one,
    // so power k ends up in lane k-2 after the last stage.
    always_ff @(posedge clk)
    begin
        if (step)
        begin
            n_q    <= d.n;
            acc_q  <= prod;
            pows_q <= {prod, d.pows[pow_pkg::n_stages - 1:1]};
        end
    end

    assign q = '{vld: vld_q, n: n_q, acc: acc_q, pows: pows_q};

endmodule

// ==== pow_pipe/pow_pipe.sv ====
`timescale 1ns/10ps

module pow_pipe
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               step,
    input  pow_pkg::pow_item_t launch,
    output pow_pkg::pow_item_t done_item
);

    logic                         in_vld;
    logic [pow_pkg::data_w - 1:0] in_n;

    pow_pkg::pow_item_t chain [0:pow_pkg::n_stages];

    // Stage-0 input register.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            in_vld <= 1'b0;
        else if (step)
            in_vld <= launch.vld;
    end

    always_ff @(posedge clk)
    begin
        if (step)
            in_n <= launch.n;
    end

    // Seed acc with n so the first stage squares.
    assign chain[0] = '{vld: in_vld, n: in_n, acc: in_n, pows: '0};

    generate
        genvar i;

        for (i = 0; i < pow_pkg::n_stages; i = i + 1)
        begin : g_stage
            pow_stage u_stage
            (
                .clk   (clk),
                .rst_n (rst_n),
                .step  (step),
                .d     (chain[i]),
                .q     (chain[i + 1])
            );
        end
    endgenerate

    assign done_item = chain[pow_pkg::n_stages];

endmodule

// ==== design/pow_regs.sv ====
`timescale 1ns/10ps

module pow_regs
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  pow_pkg::apb_req_t           apb_req,
    output pow_pkg::apb_rsp_t           apb_rsp,
    input  logic                        step,
    input  pow_pkg::pow_item_t          done_item,
    output logic [pow_pkg::div_w - 1:0] div_ratio,
    output pow_pkg::pow_item_t          launch
);

    logic                                                  access;
    logic                                                  wr;
    logic                                                  addr_ok;
    logic                                                  op_busy;
    logic                                                  op_wr;
    logic                                                  ctrl_wr;
    logic                                                  err;
    logic [pow_pkg::apb_data_w - 1:0]                      rdata;

    logic                                                  pending;
    logic [pow_pkg::data_w - 1:0]                          op_n;
    logic [pow_pkg::data_w - 1:0]                          res_n;
    logic [pow_pkg::n_stages - 1:0][pow_pkg::data_w - 1:0] res_pows;
    logic [pow_pkg::cnt_w - 1:0]                           done_cnt;

    assign access = apb_req.psel && apb_req.penable;
    assign wr     = access && apb_req.pwrite;

    assign addr_ok = (apb_req.paddr == pow_pkg::addr_ctrl)
                  || (apb_req.paddr == pow_pkg::addr_operand)
                  || (apb_req.paddr == pow_pkg::addr_status)
                  || (apb_req.paddr == pow_pkg::addr_result);

    // Operand write while a launch waits for step.
    assign op_busy = wr && (apb_req.paddr == pow_pkg::addr_operand) && pending;

    assign op_wr   = wr && (apb_req.paddr == pow_pkg::addr_operand) && !pending;
    assign ctrl_wr = wr && (apb_req.paddr == pow_pkg::addr_ctrl);
    assign err     = access && (!addr_ok || op_busy);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            div_ratio <= '0;
        else if (ctrl_wr)
            div_ratio <= apb_req.pwdata[pow_pkg::div_w - 1:0];
    end

    // Held until the pipeline takes it on step.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pending <= 1'b0;
        else if (op_wr)
            pending <= 1'b1;
        else if (step)
            pending <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (op_wr)
            op_n <= apb_req.pwdata[pow_pkg::data_w - 1:0];
    end

    assign launch = '{vld: pending, n: op_n, acc: '0, pows: '0};

    // Result capture; a later completion overwrites.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            res_n    <= '0;
            res_pows <= '0;
            done_cnt <= '0;
        end
        else if (step && done_item.vld)
        begin
            res_n    <= done_item.n;
            res_pows <= done_item.pows;
            done_cnt <= done_cnt + 1'b1;
        end
    end

    always_comb
    begin
        case (apb_req.paddr)
            pow_pkg::addr_ctrl:    rdata = {24'b0, div_ratio};
            pow_pkg::addr_operand: rdata = {24'b0, res_n};
            pow_pkg::addr_status:  rdata = {16'b0, done_cnt, 7'b0, pending};
            pow_pkg::addr_result:  rdata = res_pows;
            default:               rdata = '0;
        endcase
    end

    // No wait states.
    assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: err};

endmodule

// ==== design/pow_top.sv ====
`timescale 1ns/10ps

module pow_top
(
    input  logic              clk,
    input  logic              rst_n,
    input  pow_pkg::apb_req_t apb_req,
    output pow_pkg::apb_rsp_t apb_rsp
);

    logic [pow_pkg::div_w - 1:0] div_ratio;
    logic                        step;
    pow_pkg::pow_item_t          launch;
    pow_pkg::pow_item_t          done_item;

    pow_regs u_regs
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .step      (step),
        .done_item (done_item),
        .div_ratio (div_ratio),
        .launch    (launch)
    );

    // Clock-enable pulses for the pipeline.
    step_strobe u_strobe
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .div_ratio (div_ratio),
        .step      (step)
    );

    pow_pipe u_pipe
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .launch    (launch),
        .done_item (done_item)
    );

endmodule

// ==== dv/pow_asserts.sv ====
`timescale 1ns/10ps

module pow_asserts
(
    input logic                        clk,
    input logic                        rst_n,
    input pow_pkg::apb_rsp_t           apb_rsp,
    input logic                        step,
    input pow_pkg::pow_item_t          done_item,
    input logic                        pending,
    input logic [pow_pkg::cnt_w - 1:0] done_cnt
);

    // No wait states.
    a_pready: assert property (@(posedge clk) disable iff (!rst_n) apb_rsp.pready)
        else $error("pready went low");

    // The pipeline takes the launch item only on step.
    a_pending: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(pending) |-> $past(step))
        else $error("pending cleared without a step pulse");

    a_count: assert property (@(posedge clk) disable iff (!rst_n)
        (done_cnt != $past(done_cnt)) |-> $past(step && done_item.vld))
        else $error("completion count moved without a valid item on step");

endmodule

bind pow_regs pow_asserts u_asserts
(
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_rsp   (apb_rsp),
    .step      (step),
    .done_item (done_item),
    .pending   (pending),
    .done_cnt  (done_cnt)
);

// ==== dv/pow_tb.sv ====
`timescale 1ns/10ps

module pow_tb;

    localparam int n_entries = 8;
    localparam int big_div   = 200;
    localparam int period    = 40;
    localparam int limit_ns  = (n_entries + 4) * (big_div + 1) * (pow_pkg::n_stages + 2)
                               * period + 20000;

    typedef struct packed
    {
        logic [7:0]  operand;
        logic [7:0]  div_ratio;
        logic [31:0] pows;
    } stim_t;

    logic              clk;
    logic              rst_n;
    pow_pkg::apb_req_t apb_req;
    pow_pkg::apb_rsp_t apb_rsp;

    stim_t       stim [n_entries];
    int          checks;
    int          errors;
    logic [31:0] seed;

    pow_top pow_top_i
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #(period / 2) clk = ~clk;

    initial
    begin
        #(limit_ns);
        $display("Timeout after %0d ns, the DUT stopped completing operands.", limit_ns);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Powers 2 to 5, truncated, lowest power in the low byte.
    function automatic logic [31:0] expected_pows(input logic [7:0] n);
        logic [7:0]  p;
        logic [31:0] r;
        p = n;
        r = '0;
        for (int k = 0; k < pow_pkg::n_stages; k++)
        begin
            p = p * n;
            r[k * 8 +: 8] = p;
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp)
        begin
            errors = errors + 1;
            $display("FAIL %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // Setup, then access; response sampled mid-cycle.
    task automatic apb_transfer(input logic wr, input logic [3:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        check("pready", apb_rsp.pready, 1'b1);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        logic err;
        apb_transfer(1'b0, addr, '0, data, err);
        check($sformatf("pslverr read 0x%0h", addr), err, 1'b0);
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_transfer(1'b1, addr, data, rd, err);
        check($sformatf("pslverr write 0x%0h", addr), err, 1'b0);
    endtask

    // Polls until the pipeline has taken the pending operand.
    task automatic wait_launch();
        logic [31:0] st;
        st = 32'h1;
        while (st[0])
            read_reg(pow_pkg::addr_status, st);
    endtask

    task automatic wait_completions(input logic [7:0] start, input int n);
        logic [31:0] st;
        logic [7:0]  seen;
        seen = start;
        while (8'(seen - start) < n)
        begin
            read_reg(pow_pkg::addr_status, st);
            seen = st[15:8];
        end
        check("completion count", seen, 8'(start + n));
    endtask

    task automatic check_result(input logic [7:0] n, input logic [31:0] exp_pows);
        logic [31:0] rd;
        read_reg(pow_pkg::addr_result, rd);
        check("RESULT", rd, exp_pows);
        read_reg(pow_pkg::addr_operand, rd);
        check("OPERAND", rd, {24'b0, n});
    endtask

    initial
    begin
        logic [31:0] rd;
        logic        err;
        logic [7:0]  cnt0;
        logic [7:0]  last_n;
        logic [31:0] snap [4];

        clk     = 1'b0;
        rst_n   = 1'b0;
        apb_req = '0;
        checks  = 0;
        errors  = 0;
        seed    = 32'h8f42;

        stim[0] = '{operand: 8'h00, div_ratio: 8'd0, pows: 32'h0000_0000};
        stim[1] = '{operand: 8'h01, div_ratio: 8'd1, pows: 32'h0101_0101};
        stim[2] = '{operand: 8'h02, div_ratio: 8'd3, pows: 32'h2010_0804};
        stim[3] = '{operand: 8'hff, div_ratio: 8'd7, pows: 32'hff01_ff01};
        stim[4] = '{operand: 8'h03, div_ratio: 8'd2, pows: 32'hf351_1b09};
        for (int i = 5; i < n_entries; i++)
        begin
            seed    = xorshift(seed);
            stim[i] = '{operand: seed[7:0], div_ratio: 8'(i * 4),
                        pows: expected_pows(seed[7:0])};
        end

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        read_reg(pow_pkg::addr_status, rd);
        check("STATUS after reset", rd, 32'h0);
        read_reg(pow_pkg::addr_ctrl, rd);
        check("CTRL after reset", rd, 32'h0);
        read_reg(pow_pkg::addr_result, rd);
        check("RESULT after reset", rd, 32'h0);

        // One operand at a time.
        for (int i = 0; i < n_entries; i++)
        begin
            read_reg(pow_pkg::addr_status, rd);
            cnt0 = rd[15:8];
            write_reg(pow_pkg::addr_ctrl, {24'b0, stim[i].div_ratio});
            write_reg(pow_pkg::addr_operand, {24'b0, stim[i].operand});
            wait_completions(cnt0, 1);
            check_result(stim[i].operand, stim[i].pows);
        end

        // Full rate once the divider has reloaded, so later writes overlap in the pipe.
        write_reg(pow_pkg::addr_ctrl, 32'h0);
        read_reg(pow_pkg::addr_status, rd);
        cnt0 = rd[15:8];
        for (int i = 0; i < 6; i++)
        begin
            seed   = xorshift(seed);
            last_n = seed[7:0];
            write_reg(pow_pkg::addr_operand, {24'b0, last_n});
            if (i == 0)
                wait_launch();
        end
        wait_completions(cnt0, 6);
        check_result(last_n, expected_pows(last_n));

        // Slow steps, a completion aligns the testbench just after a step.
        write_reg(pow_pkg::addr_ctrl, big_div);
        read_reg(pow_pkg::addr_status, rd);
        cnt0 = rd[15:8];
        write_reg(pow_pkg::addr_operand, 32'h5a);
        wait_completions(cnt0, 1);
        cnt0   = cnt0 + 8'd1;
        seed   = xorshift(seed);
        last_n = seed[7:0];
        write_reg(pow_pkg::addr_operand, {24'b0, last_n});
        apb_transfer(1'b1, pow_pkg::addr_operand, {24'b0, ~last_n}, rd, err);
        check("pslverr operand while pending", err, 1'b1);
        wait_completions(cnt0, 1);
        check_result(last_n, expected_pows(last_n));

        // Unmapped offsets.
        for (int i = 0; i < 4; i++)
            read_reg(4'(i * 4), snap[i]);
        apb_transfer(1'b1, 4'h2, 32'hffff_ffff, rd, err);
        check("pslverr write 0x2", err, 1'b1);
        apb_transfer(1'b0, 4'h7, 32'h0, rd, err);
        check("pslverr read 0x7", err, 1'b1);
        apb_transfer(1'b1, 4'hd, 32'h0000_00a5, rd, err);
        check("pslverr write 0xd", err, 1'b1);
        for (int i = 0; i < 4; i++)
        begin
            read_reg(4'(i * 4), rd);
            check($sformatf("register 0x%0h unchanged", i * 4), rd, snap[i]);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== compile.f ====
common/pow_pkg.sv
design/step_strobe.sv
pow_pipe/pow_stage.sv
pow_pipe/pow_pipe.sv
design/pow_regs.sv
design/pow_top.sv
dv/pow_asserts.sv
dv/pow_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pow_tb -f compile.f \
    -o pow_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/pow_sim > sim.log 2>&1 || echo "Simulation exited with an error"
cat sim.log
grep -q "All checks passed" sim.log && exit 0 || exit 1
